//--- core_pkg.sv
// Widths, opcodes, ALU operation codes, buffer and credit sizes, FSM state codes
// and the instruction word union with its R, I and U views.
package core_pkg;

    // Data and instruction widths.
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ALU operation codes.
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    // Major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Instruction buffer depth, also the source's initial credit count.
    localparam int INSTR_FIFO_DEPTH = 4;
    localparam int INSTR_PTR_W      = $clog2(INSTR_FIFO_DEPTH);

    // Commit records in flight before a credit returns.
    localparam int COMMIT_CREDITS = 2;
    localparam int COMMIT_CNT_W   = $clog2(COMMIT_CREDITS + 1);

    // Execution FSM states.
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE    = 2'd0;
    localparam logic [ST_W-1:0] ST_DECODE  = 2'd1;
    localparam logic [ST_W-1:0] ST_EXECUTE = 2'd2;
    localparam logic [ST_W-1:0] ST_COMMIT  = 2'd3;

    // One instruction word, three decodings.
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [19:0]           imm;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } instr_u;

endpackage

//--- instr_buffer.sv
// Instruction FIFO on the input stream.
// Returns one credit to the source per word popped.
`timescale 1ns/1ns

module instr_buffer import core_pkg::*; (
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_instr_valid,
    input  instr_u i_instr,
    input  logic   i_pop,
    output instr_u o_head,
    output logic   o_not_empty,
    output logic   o_instr_credit
);

    instr_u                 mem [INSTR_FIFO_DEPTH];
    logic [INSTR_PTR_W-1:0] wr_ptr;
    logic [INSTR_PTR_W-1:0] rd_ptr;
    logic [INSTR_PTR_W:0]   count;

    //------------------------------------------------------------
    // Storage.
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            mem[wr_ptr] <= i_instr;
        end
    end

    assign o_head      = mem[rd_ptr];
    assign o_not_empty = (count != '0);

    //------------------------------------------------------------
    // Pointers, occupancy and credit return.
    //------------------------------------------------------------
    // The source never writes without a credit, so no full check.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            o_instr_credit <= 1'b0;
        end else begin
            if (i_instr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_instr_valid, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            o_instr_credit <= i_pop;
        end
    end

endmodule

//--- reg_file.sv
// Integer register file, two combinational read ports and one write port.
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [REG_ADDR_W-1:0] i_raddr_a,
    input  logic [REG_ADDR_W-1:0] i_raddr_b,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata,
    output logic [XLEN-1:0]       o_rdata_a,
    output logic [XLEN-1:0]       o_rdata_b
);

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Reads of x0 return zero.
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

//--- alu.sv
// 64-bit integer ALU: add, sub, logic ops, compares, shifts, pass-through.
`timescale 1ns/1ns

module alu import core_pkg::*; (
    input  logic [ALU_OP_W-1:0] i_op,
    input  logic [XLEN-1:0]     i_src_a,
    input  logic [XLEN-1:0]     i_src_b,
    output logic [XLEN-1:0]     o_result
);

    // RV64 shift amount.
    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_src_b[5:0];
    assign lt_signed   = ($signed(i_src_a) < $signed(i_src_b));
    assign lt_unsigned = (i_src_a < i_src_b);

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_src_a + i_src_b;
            ALU_SUB:    o_result = i_src_a - i_src_b;
            ALU_AND:    o_result = i_src_a & i_src_b;
            ALU_OR:     o_result = i_src_a | i_src_b;
            ALU_XOR:    o_result = i_src_a ^ i_src_b;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:    o_result = i_src_a << shamt;
            ALU_SRL:    o_result = i_src_a >> shamt;
            ALU_SRA:    o_result = $signed(i_src_a) >>> shamt;
            // LUI.
            ALU_PASS_B: o_result = i_src_b;
            default:    o_result = '0;
        endcase
    end

endmodule

//--- exec_control.sv
// Instruction register, decode through the instruction union, immediate extension
// and the idle, decode, execute, commit FSM.
`timescale 1ns/1ns

module exec_control import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  instr_u                i_head,
    input  logic                  i_not_empty,
    input  logic [XLEN-1:0]       i_rdata_a,
    input  logic [XLEN-1:0]       i_rdata_b,
    input  logic [XLEN-1:0]       i_alu_result,
    input  logic                  i_accept,
    output logic                  o_pop,
    output logic [REG_ADDR_W-1:0] o_raddr_a,
    output logic [REG_ADDR_W-1:0] o_raddr_b,
    output logic                  o_reg_we,
    output logic [REG_ADDR_W-1:0] o_reg_waddr,
    output logic [XLEN-1:0]       o_reg_wdata,
    output logic [ALU_OP_W-1:0]   o_alu_op,
    output logic [XLEN-1:0]       o_alu_a,
    output logic [XLEN-1:0]       o_alu_b,
    output logic                  o_commit_req,
    output logic [REG_ADDR_W-1:0] o_commit_rd,
    output logic [XLEN-1:0]       o_commit_value,
    output logic                  o_commit_illegal
);

    logic [ST_W-1:0] state;
    instr_u          instr_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] result_q;

    logic [ALU_OP_W-1:0] s_alu_op;
    logic [XLEN-1:0]     s_imm;
    logic                s_use_imm;
    logic                s_illegal;

    //------------------------------------------------------------
    // Decode of the latched instruction.
    //------------------------------------------------------------
    always_comb begin
        s_alu_op  = ALU_ADD;
        s_imm     = '0;
        s_use_imm = 1'b0;
        s_illegal = 1'b0;
        case (instr_q.r.opcode)
            OPC_OP: begin
                // funct7 then funct3.
                case ({instr_q.r.funct7, instr_q.r.funct3})
                    10'b0000000_000: s_alu_op = ALU_ADD;
                    10'b0100000_000: s_alu_op = ALU_SUB;
                    10'b0000000_001: s_alu_op = ALU_SLL;
                    10'b0000000_010: s_alu_op = ALU_SLT;
                    10'b0000000_011: s_alu_op = ALU_SLTU;
                    10'b0000000_100: s_alu_op = ALU_XOR;
                    10'b0000000_101: s_alu_op = ALU_SRL;
                    10'b0100000_101: s_alu_op = ALU_SRA;
                    10'b0000000_110: s_alu_op = ALU_OR;
                    10'b0000000_111: s_alu_op = ALU_AND;
                    default:         s_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                s_use_imm = 1'b1;
                s_imm     = {{(XLEN-12){instr_q.i.imm[11]}}, instr_q.i.imm};
                // Immediate shifts are not supported.
                case (instr_q.i.funct3)
                    3'b000:  s_alu_op = ALU_ADD;
                    3'b010:  s_alu_op = ALU_SLT;
                    3'b011:  s_alu_op = ALU_SLTU;
                    3'b100:  s_alu_op = ALU_XOR;
                    3'b110:  s_alu_op = ALU_OR;
                    3'b111:  s_alu_op = ALU_AND;
                    default: s_illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                s_use_imm = 1'b1;
                s_alu_op  = ALU_PASS_B;
                s_imm     = {{(XLEN-ILEN){instr_q.u.imm[19]}}, instr_q.u.imm, 12'b0};
            end
            default: s_illegal = 1'b1;
        endcase
    end

    //------------------------------------------------------------
    // FSM.
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (i_not_empty) state <= ST_DECODE;
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: state <= ST_COMMIT;
                ST_COMMIT:  if (i_accept) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Instruction and operands latch in decode, result in execute.
    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            instr_q <= i_head;
            rs1_q   <= i_rdata_a;
            rs2_q   <= i_rdata_b;
        end
        if (state == ST_EXECUTE) begin
            result_q <= s_illegal ? '0 : i_alu_result;
        end
    end

    //------------------------------------------------------------
    // Outputs.
    //------------------------------------------------------------
    assign o_pop     = (state == ST_DECODE);
    assign o_raddr_a = i_head.r.rs1;
    assign o_raddr_b = i_head.r.rs2;

    assign o_alu_op = s_alu_op;
    assign o_alu_a  = rs1_q;
    assign o_alu_b  = s_use_imm ? s_imm : rs2_q;

    // Write back together with the accept.
    assign o_reg_we    = (state == ST_COMMIT) && i_accept && !s_illegal;
    assign o_reg_waddr = instr_q.r.rd;
    assign o_reg_wdata = result_q;

    assign o_commit_req     = (state == ST_COMMIT);
    assign o_commit_rd      = instr_q.r.rd;
    assign o_commit_value   = result_q;
    assign o_commit_illegal = s_illegal;

endmodule

//--- commit_port.sv
// Commit credit counter and the registered commit record.
`timescale 1ns/1ns

module commit_port import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_commit_req,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_value,
    input  logic                  i_illegal,
    input  logic                  i_commit_credit,
    output logic                  o_accept,
    output logic                  o_commit_valid,
    output logic [REG_ADDR_W-1:0] o_commit_rd,
    output logic [XLEN-1:0]       o_commit_value,
    output logic                  o_commit_illegal
);

    logic [COMMIT_CNT_W-1:0] credits;

    // Take a record only while the sink has room.
    assign o_accept = i_commit_req && (credits != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits        <= COMMIT_CNT_W'(COMMIT_CREDITS);
            o_commit_valid <= 1'b0;
        end else begin
            case ({o_accept, i_commit_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            o_commit_valid <= o_accept;
        end
    end

    // Record fields.
    always_ff @(posedge clk) begin
        if (o_accept) begin
            o_commit_rd      <= i_rd;
            o_commit_value   <= i_value;
            o_commit_illegal <= i_illegal;
        end
    end

endmodule

//--- rv_core_top.sv
// Top level of the streaming integer core: input buffer, execution control,
// register file, ALU and commit port.
`timescale 1ns/1ns

module rv_core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_instr_valid,
    input  instr_u                i_instr,
    input  logic                  i_commit_credit,
    output logic                  o_instr_credit,
    output logic                  o_commit_valid,
    output logic [REG_ADDR_W-1:0] o_commit_rd,
    output logic [XLEN-1:0]       o_commit_value,
    output logic                  o_commit_illegal
);

    //------------------------------------------------------------
    // Internal nets.
    //------------------------------------------------------------
    instr_u                s_head;
    logic                  s_not_empty;
    logic                  s_pop;
    logic [REG_ADDR_W-1:0] s_raddr_a;
    logic [REG_ADDR_W-1:0] s_raddr_b;
    logic [XLEN-1:0]       s_rdata_a;
    logic [XLEN-1:0]       s_rdata_b;
    logic                  s_reg_we;
    logic [REG_ADDR_W-1:0] s_reg_waddr;
    logic [XLEN-1:0]       s_reg_wdata;
    logic [ALU_OP_W-1:0]   s_alu_op;
    logic [XLEN-1:0]       s_alu_a;
    logic [XLEN-1:0]       s_alu_b;
    logic [XLEN-1:0]       s_alu_result;
    logic                  s_commit_req;
    logic [REG_ADDR_W-1:0] s_commit_rd;
    logic [XLEN-1:0]       s_commit_value;
    logic                  s_commit_illegal;
    logic                  s_accept;

    //------------------------------------------------------------
    // Input side.
    //------------------------------------------------------------
    instr_buffer instr_buf (
        .clk            ( clk            ),
        .i_rst_n        ( i_rst_n        ),
        .i_instr_valid  ( i_instr_valid  ),
        .i_instr        ( i_instr        ),
        .i_pop          ( s_pop          ),
        .o_head         ( s_head         ),
        .o_not_empty    ( s_not_empty    ),
        .o_instr_credit ( o_instr_credit )
    );

    //------------------------------------------------------------
    // Execution.
    //------------------------------------------------------------
    exec_control exec_ctrl (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_head           ( s_head           ),
        .i_not_empty      ( s_not_empty      ),
        .i_rdata_a        ( s_rdata_a        ),
        .i_rdata_b        ( s_rdata_b        ),
        .i_alu_result     ( s_alu_result     ),
        .i_accept         ( s_accept         ),
        .o_pop            ( s_pop            ),
        .o_raddr_a        ( s_raddr_a        ),
        .o_raddr_b        ( s_raddr_b        ),
        .o_reg_we         ( s_reg_we         ),
        .o_reg_waddr      ( s_reg_waddr      ),
        .o_reg_wdata      ( s_reg_wdata      ),
        .o_alu_op         ( s_alu_op         ),
        .o_alu_a          ( s_alu_a          ),
        .o_alu_b          ( s_alu_b          ),
        .o_commit_req     ( s_commit_req     ),
        .o_commit_rd      ( s_commit_rd      ),
        .o_commit_value   ( s_commit_value   ),
        .o_commit_illegal ( s_commit_illegal )
    );

    reg_file regs (
        .clk       ( clk         ),
        .i_rst_n   ( i_rst_n     ),
        .i_raddr_a ( s_raddr_a   ),
        .i_raddr_b ( s_raddr_b   ),
        .i_we      ( s_reg_we    ),
        .i_waddr   ( s_reg_waddr ),
        .i_wdata   ( s_reg_wdata ),
        .o_rdata_a ( s_rdata_a   ),
        .o_rdata_b ( s_rdata_b   )
    );

    alu alu_unit (
        .i_op     ( s_alu_op     ),
        .i_src_a  ( s_alu_a      ),
        .i_src_b  ( s_alu_b      ),
        .o_result ( s_alu_result )
    );

    //------------------------------------------------------------
    // Output side.
    //------------------------------------------------------------
    commit_port commit (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_commit_req     ( s_commit_req     ),
        .i_rd             ( s_commit_rd      ),
        .i_value          ( s_commit_value   ),
        .i_illegal        ( s_commit_illegal ),
        .i_commit_credit  ( i_commit_credit  ),
        .o_accept         ( s_accept         ),
        .o_commit_valid   ( o_commit_valid   ),
        .o_commit_rd      ( o_commit_rd      ),
        .o_commit_value   ( o_commit_value   ),
        .o_commit_illegal ( o_commit_illegal )
    );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset generator: 10 ns clock, reset low for 5 cycles.
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Release just after a rising edge, away from both clock edges.
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- tb_rv_core.sv
// Testbench for rv_core_top with an instruction table of expected commits,
// a credit-driven source, randomly delayed sink credits and a back-pressure check.
`timescale 1ns/1ns

module tb_rv_core import core_pkg::*; ();

    logic                  clk;
    logic                  rst_n;
    logic                  i_instr_valid;
    instr_u                i_instr;
    logic                  i_commit_credit;
    logic                  o_instr_credit;
    logic                  o_commit_valid;
    logic [REG_ADDR_W-1:0] o_commit_rd;
    logic [XLEN-1:0]       o_commit_value;
    logic                  o_commit_illegal;

    // Stimulus and expected-value table.
    string                 row_name[$];
    instr_u                row_word[$];
    logic [REG_ADDR_W-1:0] row_rd[$];
    logic [XLEN-1:0]       row_value[$];
    logic                  row_illegal[$];
    int                    phase_a_rows;

    int errors       = 0;
    int checks       = 0;
    int errs_before  = 0;
    int words_sent   = 0;
    int credits_back = 0;
    int received     = 0;
    int owed         = 0;
    int credit_delay = 0;
    int pool_idx     = 0;
    int max_outstand = 0;
    bit range_flagged = 1'b0;
    bit hold         = 1'b0;
    int delay_pool [256];

    tb_clock_gen clock_gen (
        .o_clk   ( clk   ),
        .o_rst_n ( rst_n )
    );

    rv_core_top UUT (
        .clk              ( clk              ),
        .i_rst_n          ( rst_n            ),
        .i_instr_valid    ( i_instr_valid    ),
        .i_instr          ( i_instr          ),
        .i_commit_credit  ( i_commit_credit  ),
        .o_instr_credit   ( o_instr_credit   ),
        .o_commit_valid   ( o_commit_valid   ),
        .o_commit_rd      ( o_commit_rd      ),
        .o_commit_value   ( o_commit_value   ),
        .o_commit_illegal ( o_commit_illegal )
    );

    //------------------------------------------------------------
    // Instruction encoders in the ISA field layout.
    //------------------------------------------------------------
    function automatic instr_u r_type_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        instr_u w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = funct3;
        w.r.rd     = rd;
        w.r.opcode = OPC_OP;
        return w;
    endfunction

    function automatic instr_u i_type_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = funct3;
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    function automatic instr_u lui_word(input logic [4:0] rd, input logic [19:0] imm);
        instr_u w;
        w.u.imm    = imm;
        w.u.rd     = rd;
        w.u.opcode = OPC_LUI;
        return w;
    endfunction

    function automatic int credits_held();
        return INSTR_FIFO_DEPTH - words_sent + credits_back;
    endfunction

    task automatic add_row(input string name, input instr_u word, input logic [4:0] rd,
                           input logic [XLEN-1:0] value, input logic illegal);
        row_name.push_back(name);
        row_word.push_back(word);
        row_rd.push_back(rd);
        row_value.push_back(value);
        row_illegal.push_back(illegal);
    endtask

    // Expected values follow the RV64I rules with x0 reading zero and registers
    // starting at zero.
    task automatic build_table();
        add_row("add",   r_type_word(7'h00, 3'b000, 3, 1, 2), 3, 64'd0, 1'b0);
        add_row("addi",  i_type_word(OPC_OP_IMM, 3'b000, 1, 0, 12'd5), 1, 64'd5, 1'b0);
        add_row("addi",  i_type_word(OPC_OP_IMM, 3'b000, 2, 0, 12'hffd), 2,
                64'hffff_ffff_ffff_fffd, 1'b0);
        add_row("lui",   lui_word(3, 20'h12345), 3, 64'h0000_0000_1234_5000, 1'b0);
        add_row("lui",   lui_word(4, 20'h80000), 4, 64'hffff_ffff_8000_0000, 1'b0);
        add_row("add",   r_type_word(7'h00, 3'b000, 5, 1, 2), 5, 64'd2, 1'b0);
        add_row("sub",   r_type_word(7'h20, 3'b000, 6, 1, 2), 6, 64'd8, 1'b0);
        add_row("or",    r_type_word(7'h00, 3'b110, 7, 1, 3), 7, 64'h1234_5005, 1'b0);
        add_row("xor",   r_type_word(7'h00, 3'b100, 8, 2, 4), 8, 64'h0000_0000_7fff_fffd, 1'b0);
        add_row("and",   r_type_word(7'h00, 3'b111, 9, 2, 4), 9, 64'hffff_ffff_8000_0000, 1'b0);
        add_row("slt",   r_type_word(7'h00, 3'b010, 10, 2, 1), 10, 64'd1, 1'b0);
        add_row("sltu",  r_type_word(7'h00, 3'b011, 11, 2, 1), 11, 64'd0, 1'b0);
        add_row("sll",   r_type_word(7'h00, 3'b001, 12, 1, 1), 12, 64'ha0, 1'b0);
        add_row("srl",   r_type_word(7'h00, 3'b101, 13, 4, 1), 13, 64'h07ff_ffff_fc00_0000, 1'b0);
        add_row("sra",   r_type_word(7'h20, 3'b101, 14, 4, 1), 14, 64'hffff_ffff_fc00_0000, 1'b0);
        add_row("slti",  i_type_word(OPC_OP_IMM, 3'b010, 15, 2, 12'hffe), 15, 64'd1, 1'b0);
        add_row("sltiu", i_type_word(OPC_OP_IMM, 3'b011, 16, 1, 12'hfff), 16, 64'd1, 1'b0);
        add_row("andi",  i_type_word(OPC_OP_IMM, 3'b111, 17, 2, 12'h0f0), 17, 64'hf0, 1'b0);
        add_row("ori",   i_type_word(OPC_OP_IMM, 3'b110, 18, 1, 12'hff0), 18,
                64'hffff_ffff_ffff_fff5, 1'b0);
        add_row("xori",  i_type_word(OPC_OP_IMM, 3'b100, 19, 2, 12'hfff), 19, 64'd2, 1'b0);
        // Write to x0, then read it back.
        add_row("addi",  i_type_word(OPC_OP_IMM, 3'b000, 0, 1, 12'd7), 0, 64'd12, 1'b0);
        add_row("add",   r_type_word(7'h00, 3'b000, 20, 0, 1), 20, 64'd5, 1'b0);
        // Load opcode and MUL are illegal here. Their rd must stay as it was.
        add_row("load",  i_type_word(7'b0000011, 3'b011, 5, 1, 12'd0), 5, 64'd0, 1'b1);
        add_row("add",   r_type_word(7'h00, 3'b000, 21, 5, 0), 21, 64'd2, 1'b0);
        add_row("mul",   r_type_word(7'h01, 3'b000, 6, 1, 2), 6, 64'd0, 1'b1);
        add_row("addi",  i_type_word(OPC_OP_IMM, 3'b000, 22, 6, 12'd0), 22, 64'd8, 1'b0);
        add_row("slt",   r_type_word(7'h00, 3'b010, 24, 1, 2), 24, 64'd0, 1'b0);
        add_row("sltu",  r_type_word(7'h00, 3'b011, 25, 1, 2), 25, 64'd1, 1'b0);
        phase_a_rows = row_name.size();
        // Back-pressure batch as a counter chain that also shows the order.
        for (int k = 1; k <= 10; k++) begin
            add_row("inc", i_type_word(OPC_OP_IMM, 3'b000, 23, 23, 12'd1), 23, 64'(k), 1'b0);
        end
    endtask

    //------------------------------------------------------------
    // Compare tasks.
    //------------------------------------------------------------
    task automatic check_rd(input int row, input logic [REG_ADDR_W-1:0] got,
                            input logic [REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns row %0d o_commit_rd: got %0d, expected %0d",
                     $time, row, got, exp);
        end
    endtask

    task automatic check_value(input int row, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns row %0d o_commit_value: got %h, expected %h",
                     $time, row, got, exp);
        end
    endtask

    task automatic check_illegal(input int row, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns row %0d o_commit_illegal: got %b, expected %b",
                     $time, row, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    //------------------------------------------------------------
    // Source side and waits.
    //------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("Timeout at %0t ns: %s", $time, reason);
        $display("Testbench failed");
        $finish;
    endtask

    // One-cycle valid pulse sent only while a credit is held.
    task automatic send_word(input instr_u word);
        int waited;
        waited = 0;
        @(posedge clk);
        while (credits_held() <= 0) begin
            if (waited >= 200) abort_run("no input credit came back");
            waited++;
            @(posedge clk);
        end
        @(negedge clk);
        i_instr_valid = 1'b1;
        i_instr       = word;
        words_sent++;
        @(negedge clk);
        i_instr_valid = 1'b0;
    endtask

    task automatic wait_records(input int target, input int limit);
        int waited;
        waited = 0;
        while (received < target) begin
            if (waited >= limit) abort_run("commit records stopped arriving");
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic wait_credits_back(input int limit);
        int waited;
        waited = 0;
        while (credits_back < words_sent) begin
            if (waited >= limit) abort_run("input credits not all returned");
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic wait_reset_release(input int limit);
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited >= limit) abort_run("reset never released");
            waited++;
            @(posedge clk);
        end
    endtask

    //------------------------------------------------------------
    // Monitor and sink credit return on the falling edge.
    //------------------------------------------------------------
    always @(negedge clk) begin
        i_commit_credit = 1'b0;
        if (o_instr_credit === 1'b1) begin
            credits_back++;
        end
        if (o_commit_valid === 1'b1) begin
            if (received >= row_name.size()) begin
                errors++;
                $display("Unexpected commit record at %0t ns beyond the table", $time);
            end else begin
                errs_before = errors;
                check_rd(received, o_commit_rd, row_rd[received]);
                check_value(received, o_commit_value, row_value[received]);
                check_illegal(received, o_commit_illegal, row_illegal[received]);
                $display("%0t ns row %0d %s: %s", $time, received, row_name[received],
                         (errors == errs_before) ? "ok" : "mismatch");
            end
            received++;
            owed++;
        end
        // The delay runs only while a credit is owed.
        if (owed > 0 && !hold) begin
            if (credit_delay > 0) begin
                credit_delay--;
            end else begin
                i_commit_credit = 1'b1;
                owed--;
                credit_delay = delay_pool[pool_idx % 256];
                pool_idx++;
            end
        end
    end

    // Words inside the core never exceed the buffer depth plus the one in execution.
    always @(posedge clk) begin
        if (words_sent - credits_back > max_outstand) begin
            max_outstand = words_sent - credits_back;
        end
        if (!range_flagged && (words_sent - received > INSTR_FIFO_DEPTH + 1 ||
                               words_sent < credits_back)) begin
            errors++;
            range_flagged = 1'b1;
            $display("Input credits out of range at %0t ns: %0d sent, %0d credited, %0d committed",
                     $time, words_sent, credits_back, received);
        end
    end

    //------------------------------------------------------------
    // Main sequence.
    //------------------------------------------------------------
    initial begin
        int start_count;
        void'($urandom(32'h3a71));
        for (int k = 0; k < 256; k++) begin
            delay_pool[k] = $urandom_range(6, 0);
        end
        i_instr_valid   = 1'b0;
        i_instr         = '0;
        i_commit_credit = 1'b0;
        build_table();

        wait_reset_release(20);
        // Both handshakes idle before any stimulus.
        errs_before = errors;
        repeat (5) begin
            @(negedge clk);
            check_flag("o_instr_credit", o_instr_credit, 1'b0);
            check_flag("o_commit_valid", o_commit_valid, 1'b0);
        end
        $display("%0t ns idle after reset: %s", $time, (errors == errs_before) ? "ok" : "mismatch");

        for (int k = 0; k < phase_a_rows; k++) begin
            send_word(row_word[k]);
        end
        wait_records(phase_a_rows, 500);

        // Withhold sink credits while the next batch streams in.
        @(posedge clk);
        hold        = 1'b1;
        start_count = received;
        fork
            begin
                for (int k = phase_a_rows; k < row_name.size(); k++) begin
                    send_word(row_word[k]);
                end
            end
            begin
                repeat (30) @(posedge clk);
                if (received - start_count > COMMIT_CREDITS) begin
                    errors++;
                    $display("%0d records arrived with credits withheld, limit is %0d",
                             received - start_count, COMMIT_CREDITS);
                end
                if (credits_held() != 0) begin
                    errors++;
                    $display("Source still held %0d input credits under back-pressure",
                             credits_held());
                end
                $display("%0t ns back-pressure: %0d records, %0d words outstanding",
                         $time, received - start_count, max_outstand);
                hold = 1'b0;
            end
        join

        wait_records(row_name.size(), 500);
        wait_credits_back(50);
        repeat (10) @(posedge clk);

        $display("%0d records, %0d checks, %0d errors", received, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
core_pkg.sv
instr_buffer.sv
reg_file.sv
alu.sv
exec_control.sv
commit_port.sv
rv_core_top.sv
tb_clock_gen.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - core_pkg.sv
  - instr_buffer.sv
  - reg_file.sv
  - alu.sv
  - exec_control.sv
  - commit_port.sv
  - rv_core_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rv_core.sv
